// File: Makefile
SRCS := verilog/accel_pkg.sv verilog/accel_regs.sv verilog/scratch_mem.sv \
        verilog/reduce_unit.sv verilog/accel_instance.sv \
        test/accel_asserts.sv test/accel_tb.sv

.PHONY: run clean

run: obj_dir/Vaccel_tb
	./obj_dir/Vaccel_tb

obj_dir/Vaccel_tb: vlog.f $(SRCS)
	verilator --binary --assert --timing --top-module accel_tb -f vlog.f

clean:
	rm -rf obj_dir

// File: test/accel_asserts.sv
module accel_asserts import accel_pkg::*; (
   input logic                    clk,
   input logic                    rst_int,
   input logic                    valid,
   input logic                    ready,
   input logic                    run,
   input logic                    unit_rst,
   input unit_cfg_t [n_units-1:0] cfg,
   input logic [n_units-1:0]      unit_done
);

   // ############################################################
   // host handshake.
   // ############################################################

   a_ready_after_valid: assert property (@(posedge clk) disable iff (rst_int)
      valid |=> ready)
      else $error("ready did not follow valid by one cycle");

   a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst_int)
      ready |-> $past(valid))
      else $error("ready seen without valid one cycle earlier");

   a_run_single: assert property (@(posedge clk) disable iff (rst_int)
      run |=> !run)
      else $error("run pulse lasted more than one cycle");

   // ############################################################
   // per-unit done flags.
   // ############################################################

   for (genvar i = 0; i < n_units; i++) begin : g_unit
      a_done_low_after_run: assert property (@(posedge clk) disable iff (rst_int)
         run && $past(unit_done[i]) && (cfg[i].length != '0) |=> !unit_done[i])
         else $error("unit %0d done came back right after a non-empty run", i);

      a_done_falls_on_run: assert property (@(posedge clk) disable iff (rst_int)
         $fell(unit_done[i]) |-> run)
         else $error("unit %0d done dropped without a run pulse", i);

      a_done_in_reset: assert property (@(posedge clk) disable iff (rst_int)
         unit_rst |-> unit_done[i])
         else $error("unit %0d not done while held in reset", i);
   end

endmodule

// File: test/accel_tb.sv
module accel_tb import accel_pkg::*;;

   logic  clk;
   logic  rst_int;
   logic  valid;
   addr_t addr;
   strb_t wstrb;
   word_t wdata;
   logic  ready;
   word_t rdata;

   word_t     model [n_units][16];  // expected scratch contents.
   unit_cfg_t cur_cfg [n_units];

   accel_instance accel_instance_i (
      .clk     (clk),
      .rst_int (rst_int),
      .valid   (valid),
      .addr    (addr),
      .wstrb   (wstrb),
      .wdata   (wdata),
      .ready   (ready),
      .rdata   (rdata)
   );

   bind accel_instance accel_asserts asserts_i (
      .clk       (clk),
      .rst_int   (rst_int),
      .valid     (valid),
      .ready     (ready),
      .run       (run),
      .unit_rst  (unit_rst),
      .cfg       (cfg),
      .unit_done (unit_done)
   );

   always #5 clk = ~clk;

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t got);
      assert (got == exp) else
         fail_now($sformatf("[FAIL] %s expected 0x%08h got 0x%08h", name, exp, got));
   endtask

   task automatic wait_ready(output word_t data);
      int   n;
      logic seen;
      seen = 1'b0;
      data = '0;
      for (n = 0; n < 8 && !seen; n++) begin
         @(negedge clk);                         // outputs settled here.
         if (ready) begin
            seen = 1'b1;
            data = rdata;
         end
      end
      assert (seen) else fail_now("no ready from the DUT within 8 cycles of an access");
   endtask

   // ############################################################
   // host accesses, valid held for one cycle.
   // ############################################################

   task automatic host_access(input addr_t a, input strb_t s, input word_t d,
                              output word_t data);
      @(posedge clk);
      valid <= 1'b1;
      addr  <= a;
      wstrb <= s;
      wdata <= d;
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= '0;
      wait_ready(data);
   endtask

   task automatic host_write(input addr_t a, input strb_t s, input word_t d);
      word_t unused;
      host_access(a, s, d, unused);
      if (a[mapped_bit]) begin
         for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
               model[a[unit_sel_bit]][a[3:0]][8*b +: 8] = d[8*b +: 8];
            end
         end
      end
   endtask

   task automatic host_read(input addr_t a, output word_t data);
      host_access(a, '0, '0, data);
   endtask

   function automatic addr_t mapped_addr(input int u, input int w);
      return addr_t'((1 << mapped_bit) | (u << unit_sel_bit) | (w & 15));
   endfunction

   function automatic unit_cfg_t random_cfg();
      unit_cfg_t c;
      c.start  = mem_addr_t'($urandom % 16);
      c.length = len_t'($urandom % 17);
      c.op     = 1'($urandom % 2);
      return c;
   endfunction

   // wrapped window fold over the model.
   function automatic word_t expected_fold(input int u, input unit_cfg_t c);
      word_t     acc;
      mem_addr_t idx;
      acc = '0;
      idx = c.start;
      for (int k = 0; k < int'(c.length); k++) begin
         if (c.op == op_xor) begin
            acc = acc ^ model[u][idx];
         end else begin
            acc = acc + model[u][idx];
         end
         idx = idx + 4'd1;
      end
      return acc;
   endfunction

   task automatic run_and_check();
      word_t data;
      logic  any_len;
      int    polls;
      any_len = 1'b0;
      for (int u = 0; u < n_units; u++) begin
         host_write(addr_t'(cfg_base + u), 4'hf, {22'd0, cur_cfg[u]});
         any_len = any_len | (cur_cfg[u].length != '0);
      end
      host_write(ctrl_addr, 4'hf, 32'h1);
      host_read(ctrl_addr, data);
      check_word("done after run", any_len ? 32'h0 : 32'h1, data);
      for (polls = 0; polls < 20 && data[0] !== 1'b1; polls++) begin
         host_read(ctrl_addr, data);
      end
      assert (data[0] === 1'b1) else fail_now("done never rose after a run");
      for (int u = 0; u < n_units; u++) begin
         host_read(addr_t'(cfg_base + u), data);
         check_word($sformatf("result[%0d]", u), expected_fold(u, cur_cfg[u]), data);
      end
   endtask

   initial begin
      word_t data;
      clk     = 1'b0;
      rst_int = 1'b1;
      valid   = 1'b0;
      addr    = '0;
      wstrb   = '0;
      wdata   = '0;
      void'($urandom(32'h5136));
      repeat (16) @(posedge clk);
      rst_int <= 1'b0;

      host_read(ctrl_addr, data);
      check_word("done after reset", 32'h1, data);
      for (int u = 0; u < n_units; u++) begin
         host_read(addr_t'(cfg_base + u), data);
         check_word($sformatf("result[%0d] after reset", u), 32'h0, data);
      end

      // fill both memories, then one partial write.
      for (int u = 0; u < n_units; u++) begin
         for (int w = 0; w < 16; w++) begin
            host_write(mapped_addr(u, w), 4'hf, $urandom);
         end
      end
      host_write(mapped_addr(1, 3), 4'b0101, 32'ha5a5_5a5a);
      for (int u = 0; u < n_units; u++) begin
         for (int w = 0; w < 16; w++) begin
            host_read(mapped_addr(u, w), data);
            check_word($sformatf("mem%0d[%0d]", u, w), model[u][w], data);
         end
      end

      cur_cfg[0] = '{op: op_add, length: len_t'(16), start: mem_addr_t'(5)};
      cur_cfg[1] = '{op: op_xor, length: len_t'(0), start: mem_addr_t'(9)};
      run_and_check();
      for (int r = 0; r < 6; r++) begin
         cur_cfg[0] = random_cfg();
         cur_cfg[1] = random_cfg();
         run_and_check();
      end

      // ############################################################
      // soft reset keeps the memories.
      // ############################################################
      host_write(ctrl_addr, 4'hf, 32'h2);
      host_read(ctrl_addr, data);
      check_word("done in soft reset", 32'h1, data);
      for (int u = 0; u < n_units; u++) begin
         host_read(addr_t'(cfg_base + u), data);
         check_word($sformatf("result[%0d] in soft reset", u), 32'h0, data);
      end
      host_write(ctrl_addr, 4'hf, 32'h0);
      cur_cfg[0] = random_cfg();
      cur_cfg[1] = '{op: op_xor, length: len_t'(11), start: mem_addr_t'(12)};
      run_and_check();

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: verilog/accel_instance.sv
module accel_instance import accel_pkg::*; (
   input  logic  clk,
   input  logic  rst_int,
   input  logic  valid,
   input  addr_t addr,
   input  strb_t wstrb,
   input  word_t wdata,
   output logic  ready,
   output word_t rdata
);

   bus_req_t                  req;
   unit_cfg_t [n_units-1:0]   cfg;
   logic                      run;
   logic                      unit_rst;
   word_t [n_units-1:0]       result;
   word_t [n_units-1:0]       rd_data;
   word_t [n_units-1:0]       mem_rdata;
   mem_addr_t [n_units-1:0]   rd_addr;
   logic [n_units-1:0]        unit_done;
   logic [n_units-1:0]        mem_ready;

   assign req = '{valid: valid, addr: addr, wstrb: wstrb, wdata: wdata};

   accel_regs regs_i (
      .clk       (clk),
      .rst_int   (rst_int),
      .req       (req),
      .result    (result),
      .unit_done (unit_done),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata),
      .cfg       (cfg),
      .run       (run),
      .unit_rst  (unit_rst),
      .ready     (ready),
      .rdata     (rdata)
   );

   // one scratch memory and one reduce unit per slot.
   for (genvar i = 0; i < n_units; i++) begin : g_unit
      scratch_mem #(
         .unit_index (i)
      ) mem_i (
         .clk       (clk),
         .rst_int   (rst_int),
         .req       (req),
         .rd_addr   (rd_addr[i]),
         .rd_data   (rd_data[i]),
         .mem_ready (mem_ready[i]),
         .mem_rdata (mem_rdata[i])
      );

      reduce_unit unit_i (
         .clk      (clk),
         .unit_rst (unit_rst),
         .run      (run),
         .cfg      (cfg[i]),
         .rd_data  (rd_data[i]),
         .rd_addr  (rd_addr[i]),
         .result   (result[i]),
         .done     (unit_done[i])
      );
   end

endmodule

// File: verilog/accel_pkg.sv
package accel_pkg;

   // ############################################################
   // widths.
   // ############################################################

   typedef logic [7:0]  addr_t;      // host word address.
   typedef logic [31:0] word_t;
   typedef logic [3:0]  strb_t;
   typedef logic [3:0]  mem_addr_t;  // scratch word index.
   typedef logic [4:0]  len_t;       // window length, 0 to 16.

   // ############################################################
   // address map.
   // ############################################################

   localparam int n_units      = 2;
   localparam int mapped_bit   = 7;  // set for scratch memory space.
   localparam int unit_sel_bit = 4;  // picks the memory inside mapped space.

   localparam addr_t ctrl_addr = 8'd0;
   localparam addr_t cfg_base  = 8'd1;  // unit i sits at cfg_base + i.

   localparam logic op_add = 1'b0;
   localparam logic op_xor = 1'b1;

   // ############################################################
   // structs and state.
   // ############################################################

   // laid out as wdata[9:0]: op, length, start.
   typedef struct packed {
      logic      op;
      len_t      length;
      mem_addr_t start;
   } unit_cfg_t;

   typedef struct packed {
      logic  valid;
      addr_t addr;
      strb_t wstrb;
      word_t wdata;
   } bus_req_t;

   typedef enum logic [1:0] {
      idle,
      busy,
      drain
   } reduce_state_t;

endpackage

// File: verilog/accel_regs.sv
module accel_regs import accel_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_int,
   input  bus_req_t                req,
   input  word_t [n_units-1:0]     result,
   input  logic [n_units-1:0]      unit_done,
   input  logic [n_units-1:0]      mem_ready,
   input  word_t [n_units-1:0]     mem_rdata,
   output unit_cfg_t [n_units-1:0] cfg,
   output logic                    run,
   output logic                    unit_rst,
   output logic                    ready,
   output word_t                   rdata
);

   logic  we;
   logic  reg_sel;
   logic  ctrl_sel;
   logic  done;
   logic  soft_reset;
   logic  reg_ready;
   word_t reg_rdata;
   word_t state_read;
   word_t mem_or;

   assign we       = |req.wstrb;
   assign reg_sel  = req.valid && !req.addr[mapped_bit];
   assign ctrl_sel = reg_sel && (req.addr == ctrl_addr);
   assign done     = &unit_done;                // all units idle.
   assign unit_rst = rst_int | soft_reset;

   // per-unit result for the addressed state word.
   always_comb begin
      state_read = '0;
      for (int i = 0; i < n_units; i++) begin
         if (req.addr == addr_t'(cfg_base + i)) begin
            state_read = result[i];
         end
      end
   end

   // ############################################################
   // host side, cleared by rst_int alone.
   // ############################################################

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_reset <= 1'b0;
         reg_ready  <= 1'b0;
         reg_rdata  <= '0;
      end else begin
         reg_ready <= reg_sel;                  // answer one cycle later.
         if (ctrl_sel && we) begin
            soft_reset <= req.wdata[1];
         end
         if (reg_sel) begin
            reg_rdata <= ctrl_sel ? word_t'(done) : state_read;
         end
      end
   end

   // ############################################################
   // unit side, also cleared by the soft reset.
   // ############################################################

   always_ff @(posedge clk or posedge unit_rst) begin
      if (unit_rst) begin
         run <= 1'b0;
         cfg <= '0;
      end else begin
         run <= ctrl_sel && we && req.wdata[0];  // single-cycle pulse.
         for (int i = 0; i < n_units; i++) begin
            if (reg_sel && we && (req.addr == addr_t'(cfg_base + i))) begin
               cfg[i] <= unit_cfg_t'(req.wdata[9:0]);
            end
         end
      end
   end

   // memories drive zero when they are not answering.
   always_comb begin
      mem_or = '0;
      for (int i = 0; i < n_units; i++) begin
         mem_or = mem_or | mem_rdata[i];
      end
   end

   assign ready = reg_ready | (|mem_ready);
   assign rdata = reg_ready ? reg_rdata : mem_or;

endmodule

// File: verilog/reduce_unit.sv
module reduce_unit import accel_pkg::*; (
   input  logic      clk,
   input  logic      unit_rst,
   input  logic      run,
   input  unit_cfg_t cfg,
   input  word_t     rd_data,
   output mem_addr_t rd_addr,
   output word_t     result,
   output logic      done
);

   reduce_state_t state;
   len_t          remaining;
   logic          pending;   // rd_data holds a word of the window.
   logic          op_q;
   word_t         acc;
   word_t         acc_next;

   always_comb begin
      acc_next = acc;
      if (pending) begin
         case (op_q)
            op_add:  acc_next = acc + rd_data;
            op_xor:  acc_next = acc ^ rd_data;
            default: acc_next = acc;
         endcase
      end
   end

   // done drops in the run cycle itself.
   assign done = (state == idle) && !run;

   always_ff @(posedge clk or posedge unit_rst) begin
      if (unit_rst) begin
         state     <= idle;
         remaining <= '0;
         pending   <= 1'b0;
         rd_addr   <= '0;
         result    <= '0;
      end else begin
         pending <= (state == busy);
         case (state)
            idle: begin
               if (run) begin
                  if (cfg.length == '0) begin
                     result <= '0;             // empty window.
                  end else begin
                     state     <= busy;
                     rd_addr   <= cfg.start;
                     remaining <= cfg.length;
                  end
               end
            end
            busy: begin
               rd_addr   <= rd_addr + 1'b1;   // wraps modulo 16.
               remaining <= remaining - 1'b1;
               if (remaining == len_t'(1)) begin
                  state <= drain;
               end
            end
            drain: begin
               state  <= idle;
               result <= acc_next;            // last word folds in here.
            end
            default: state <= idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == idle) && run) begin
         acc  <= '0;
         op_q <= cfg.op;
      end else begin
         acc <= acc_next;
      end
   end

endmodule

// File: verilog/scratch_mem.sv
module scratch_mem import accel_pkg::*; #(
   parameter int unit_index = 0
) (
   input  logic      clk,
   input  logic      rst_int,
   input  bus_req_t  req,
   input  mem_addr_t rd_addr,
   output word_t     rd_data,
   output logic      mem_ready,
   output word_t     mem_rdata
);

   word_t     mem [16];
   logic      sel;
   mem_addr_t host_addr;

   assign sel = req.valid && req.addr[mapped_bit] &&
                (req.addr[unit_sel_bit] == 1'(unit_index));
   assign host_addr = req.addr[3:0];

   // byte-strobed host writes.
   always_ff @(posedge clk) begin
      if (sel) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
               mem[host_addr][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         mem_ready <= 1'b0;
         mem_rdata <= '0;
         rd_data   <= '0;
      end else begin
         mem_ready <= sel;
         mem_rdata <= sel ? mem[host_addr] : '0;  // zero when idle.
         rd_data   <= mem[rd_addr];               // unit port.
      end
   end

endmodule

// File: vlog.f
verilog/accel_pkg.sv
verilog/accel_regs.sv
verilog/scratch_mem.sv
verilog/reduce_unit.sv
verilog/accel_instance.sv
test/accel_asserts.sv
test/accel_tb.sv
